// File: Makefile
VERILATOR ?= verilator
TOP ?= board_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG ?= No errors

SRCS := $(wildcard hw/*.sv sim/*.sv)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/board_pkg.sv
`default_nettype none

package board_pkg;

// **************************************************
// Widths
// **************************************************
localparam int time_bits = 64;
localparam int led_count = 8;
localparam int matrix_chips = 4;
localparam int frame_bits = matrix_chips * 8 * 8;
localparam int pin_bits = 128;
localparam int core_debug_bits = 96;
localparam int frame_time_lsb = 12;

// **************************************************
// MAX7219 registers, rows use addresses 1 to 8
// **************************************************
localparam logic [3:0] reg_decode_mode = 4'd9;
localparam logic [3:0] reg_intensity = 4'd10;
localparam logic [3:0] reg_scan_limit = 4'd11;
localparam logic [3:0] reg_shutdown = 4'd12;
localparam logic [3:0] reg_display_test = 4'd15;

// One chip command, shifted out msb first
typedef union packed {
	logic [15:0] raw;
	struct packed {
		logic [3:0] unused;
		logic [3:0] addr;
		logic [7:0] data;
	} f;
} max7219_word_t;

endpackage

`default_nettype wire

// File: hw/board_top.sv
`timescale 1ns/1ns
`default_nettype none

module board_top #(
	parameter int HEARTBEAT_BITS = 22,
	parameter int CLK_DIV = 4,
	parameter int INTENSITY = 8
) (
	input logic clk,
	input logic arst_n,

	// Time set and read, from and to the command core
	input logic [board_pkg::time_bits-1:0] time_set,
	input logic time_set_en,
	output logic [board_pkg::time_bits-1:0] time_now,

	output logic [board_pkg::led_count-1:0] led,
	output logic drclk,

	// Debug matrix sources and the MAX7219 chain
	input logic [board_pkg::pin_bits-1:0] pin_state,
	input logic [board_pkg::core_debug_bits-1:0] core_debug,
	output logic leds_out,
	output logic leds_cs,
	output logic leds_clk
);

localparam int time_slice_bits =
	board_pkg::frame_bits - board_pkg::pin_bits - board_pkg::core_debug_bits;

logic [board_pkg::frame_bits-1:0] frame;

// **************************************************
// Time base
// **************************************************
time_base #(
	.HEARTBEAT_BITS(HEARTBEAT_BITS)
) time_base_i (
	.clk(clk),
	.arst_n(arst_n),
	.time_set(time_set),
	.time_set_en(time_set_en),
	.time_now(time_now),
	.led(led),
	.drclk(drclk)
);

// **************************************************
// Debug LED matrix
// **************************************************
// Pins on top, core debug in the middle, time at the bottom
assign frame = {pin_state, core_debug, time_now[board_pkg::frame_time_lsb +: time_slice_bits]};

matrix_display #(
	.CLK_DIV(CLK_DIV),
	.INTENSITY(INTENSITY)
) matrix_display_i (
	.clk(clk),
	.arst_n(arst_n),
	.frame(frame),
	.leds_out(leds_out),
	.leds_cs(leds_cs),
	.leds_clk(leds_clk)
);

endmodule

`default_nettype wire

// File: hw/matrix_display.sv
`timescale 1ns/1ns
`default_nettype none

module matrix_display #(
	parameter int CLK_DIV = 4,
	parameter int INTENSITY = 8
) (
	input logic clk,
	input logic arst_n,
	input logic [board_pkg::frame_bits-1:0] frame,
	output logic leds_out,
	output logic leds_cs,
	output logic leds_clk
);

localparam int div_w = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
localparam int chip_bits = board_pkg::frame_bits / board_pkg::matrix_chips;
localparam int word_bits = $bits(board_pkg::max7219_word_t);
localparam int shift_bits = word_bits * board_pkg::matrix_chips;
localparam int cnt_w = $clog2(shift_bits);
localparam logic [cnt_w-1:0] last_bit = cnt_w'(shift_bits - 1);

// Steps 0 to 4 are init commands, 5 to 12 are rows 1 to 8
localparam logic [3:0] first_row = 4'd5;
localparam logic [3:0] last_step = 4'd12;

localparam logic [1:0] st_gap = 2'd0;
localparam logic [1:0] st_low = 2'd1;
localparam logic [1:0] st_high = 2'd2;

logic [div_w-1:0] div_cnt;
logic tick;
logic [1:0] state;
logic [3:0] step;
logic [cnt_w-1:0] bit_cnt;
logic load_tx;
logic shift_tx;
logic [shift_bits-1:0] shift_q;
logic [shift_bits-1:0] tx_words;
logic [board_pkg::frame_bits-1:0] snap;
logic [board_pkg::frame_bits-1:0] row_src;
logic [2:0] row_idx;
logic [3:0] cmd_addr;
logic [7:0] cmd_data;
board_pkg::max7219_word_t word [board_pkg::matrix_chips];

// Half period prescaler for the serial clock
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		div_cnt <= '0;
	end else if (tick) begin
		div_cnt <= '0;
	end else begin
		div_cnt <= div_cnt + div_w'(1);
	end
end

assign tick = div_cnt == div_w'(CLK_DIV - 1);

// **************************************************
// Command words
// **************************************************
assign row_idx = 3'(step - first_row);

always_comb begin
	cmd_addr = {1'b0, row_idx} + 4'd1;
	cmd_data = '0;
	case (step)
		4'd0: cmd_addr = board_pkg::reg_decode_mode;
		4'd1: begin
			cmd_addr = board_pkg::reg_intensity;
			cmd_data = 8'(INTENSITY);
		end
		4'd2: begin
			cmd_addr = board_pkg::reg_scan_limit;
			cmd_data = 8'd7;
		end
		4'd3: begin
			cmd_addr = board_pkg::reg_shutdown;
			cmd_data = 8'd1;
		end
		4'd4: cmd_addr = board_pkg::reg_display_test;
		default: ;
	endcase
end

// Row 1 reads the live frame, the same edge captures it into snap
assign row_src = (step == first_row) ? frame : snap;

always_comb begin
	for (int c = 0; c < board_pkg::matrix_chips; c++) begin
		word[c].f.unused = '0;
		word[c].f.addr = cmd_addr;
		if (step < first_row)
			word[c].f.data = cmd_data;
		else
			word[c].f.data = row_src[c * chip_bits + int'(row_idx) * 8 +: 8];
		// Chip 3 lands in the top word and goes out first
		tx_words[c * word_bits +: word_bits] = word[c].raw;
	end
end

// **************************************************
// Serial shifter
// **************************************************
assign load_tx = tick && state == st_gap;
assign shift_tx = tick && state == st_high;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= st_gap;
		step <= '0;
		bit_cnt <= '0;
		leds_cs <= 1'b1;
		leds_clk <= 1'b0;
		leds_out <= 1'b0;
	end else if (tick) begin
		case (state)
			st_gap: begin
				leds_cs <= 1'b0;
				leds_out <= tx_words[shift_bits-1];
				bit_cnt <= '0;
				state <= st_low;
			end
			st_low: begin
				leds_clk <= 1'b1;
				state <= st_high;
			end
			st_high: begin
				// Data moves together with the falling clock
				leds_clk <= 1'b0;
				if (bit_cnt == last_bit) begin
					leds_cs <= 1'b1;
					leds_out <= 1'b0;
					state <= st_gap;
					step <= (step == last_step) ? first_row : step + 4'd1;
				end else begin
					leds_out <= shift_q[shift_bits-2];
					bit_cnt <= bit_cnt + cnt_w'(1);
					state <= st_low;
				end
			end
			default: state <= st_gap;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (load_tx)
		shift_q <= tx_words;
	else if (shift_tx)
		shift_q <= shift_q << 1;
	if (load_tx && step == first_row)
		snap <= frame;
end

// Chip select idle means the clock is parked low
cs_idle_clk_low_a: assert property (
	@(posedge clk) disable iff (!arst_n) leds_cs |-> !leds_clk
);

// Data settled before every sampling edge
out_stable_a: assert property (
	@(posedge clk) disable iff (!arst_n) $rose(leds_clk) |-> $stable(leds_out)
);

endmodule

`default_nettype wire

// File: hw/time_base.sv
`timescale 1ns/1ns
`default_nettype none

module time_base #(
	parameter int HEARTBEAT_BITS = 22
) (
	input logic clk,
	input logic arst_n,
	input logic [board_pkg::time_bits-1:0] time_set,
	input logic time_set_en,
	output logic [board_pkg::time_bits-1:0] time_now,
	output logic [board_pkg::led_count-1:0] led,
	output logic drclk
);

localparam int led_top = board_pkg::led_count - 1;

logic [board_pkg::time_bits-1:0] time_next;
logic beat;

// **************************************************
// System time
// **************************************************
assign time_next = time_set_en ? time_set : time_now + board_pkg::time_bits'(1);

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		time_now <= '0;
	end else begin
		time_now <= time_next;
	end
end

// **************************************************
// Heartbeat
// **************************************************
// Step on the value being loaded, so a time load can land on a beat
assign beat = time_next[HEARTBEAT_BITS-1:0] == '0;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		led <= board_pkg::led_count'(1);
	end else if (beat) begin
		led <= {led[led_top-1:0], led[led_top]};
	end
end

// Stepper driver clock, half the system clock
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		drclk <= 1'b0;
	end else begin
		drclk <= ~drclk;
	end
end

// Exactly one LED lit, across any number of rotations
led_onehot_a: assert property (
	@(posedge clk) disable iff (!arst_n) $onehot(led)
);

endmodule

`default_nettype wire

// File: sim/board_tb.sv
`timescale 1ns/1ns
`default_nettype none

module board_tb;

localparam int hb_bits = 6;
localparam int tx_timeout = 2000;

logic clk;
logic arst_n;
logic [63:0] time_set;
logic time_set_en;
logic [63:0] time_now;
logic [7:0] led;
logic drclk;
logic [127:0] pin_state;
logic [95:0] core_debug;
logic leds_out;
logic leds_cs;
logic leds_clk;

// Time and LED model
logic [63:0] m_time;
logic [63:0] m_next;
logic [7:0] m_led;
logic m_drclk;
int loads;
int beats;
int beats_on_load;
bit loads_on;

// Serial decoder
logic prev_cs;
logic prev_sclk;
logic [63:0] rx_data;
int rx_bits;
logic [255:0] rx_frame;
logic [255:0] last_frame;
int tx_seen;
int sweeps_done;
int sweeps_used;
logic [63:0] q_data[$];
int q_bits[$];
logic [255:0] q_frame[$];

int test_errs;
int total_errs;
int tests_run;
int tests_failed;

board_top #(
	.HEARTBEAT_BITS(hb_bits),
	.CLK_DIV(2)
) dut_i (.*);

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

// **************************************************
// Stimulus and models
// **************************************************
always @(posedge clk) begin
	time_set_en <= 1'b0;
	if (loads_on && $urandom_range(63) == 0) begin
		time_set_en <= 1'b1;
		// About one load in four lands on a heartbeat step
		time_set <= {$urandom, $urandom} & (($urandom_range(3) == 0) ? ~64'h3f : ~64'h0);
	end
	if (sweeps_done != sweeps_used) begin
		sweeps_used = sweeps_done;
		pin_state <= {$urandom, $urandom, $urandom, $urandom};
		core_debug <= {$urandom, $urandom, $urandom};
	end
end

always @(posedge clk) begin
	if (!arst_n) begin
		m_time = '0;
		m_led = 8'd1;
		m_drclk = 1'b0;
	end else begin
		if (time_set_en) begin
			m_next = time_set;
			loads++;
		end else begin
			m_next = m_time + 64'd1;
		end
		if (m_next[hb_bits-1:0] == '0) begin
			m_led = {m_led[6:0], m_led[7]};
			beats++;
			if (time_set_en)
				beats_on_load++;
		end
		m_time = m_next;
		m_drclk = ~m_drclk;
	end
end

// Bits are taken at each rising serial clock and words close when chip select rises
always @(negedge clk) begin
	if (!arst_n) begin
		prev_cs = 1'b1;
		prev_sclk = 1'b0;
	end else begin
		if (prev_cs && !leds_cs) begin
			rx_data = '0;
			rx_bits = 0;
			rx_frame = last_frame;
		end
		if (!leds_cs && leds_clk && !prev_sclk) begin
			rx_data = {rx_data[62:0], leds_out};
			rx_bits++;
		end
		if (!prev_cs && leds_cs) begin
			q_data.push_back(rx_data);
			q_bits.push_back(rx_bits);
			q_frame.push_back(rx_frame);
			if (tx_seen >= 5 && (tx_seen - 5) % 8 == 7)
				sweeps_done++;
			tx_seen++;
		end
		prev_cs = leds_cs;
		prev_sclk = leds_clk;
	end
	last_frame = {pin_state, core_debug, m_time[43:12]};
end

// **************************************************
// Checks
// **************************************************
task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
	assert (got === exp) else begin
		$display("error %s expected %h actual %h", name, exp, got);
		test_errs++;
	end
endtask

task automatic compare_outputs(input string name);
	@(negedge clk);
	check_value({name, " time_now"}, m_time, time_now);
	check_value({name, " led"}, 64'(m_led), 64'(led));
	check_value({name, " drclk"}, 64'(m_drclk), 64'(drclk));
	assert ($onehot(led)) else begin
		$display("%s: led is not one-hot, pattern %b", name, led);
		test_errs++;
	end
endtask

task automatic finish_test(input string name);
	$display("test %s %s, %0d errors", name, (test_errs == 0) ? "passed" : "FAILED", test_errs);
	tests_run++;
	if (test_errs != 0)
		tests_failed++;
	total_errs += test_errs;
	test_errs = 0;
endtask

task automatic next_tx(input string name, output logic ok, output logic [63:0] data,
		output int bits, output logic [255:0] frame);
	int waited;
	waited = 0;
	while (q_data.size() == 0 && waited < tx_timeout) begin
		@(posedge clk);
		waited++;
	end
	ok = q_data.size() != 0;
	data = '0;
	bits = 0;
	frame = '0;
	if (!ok) begin
		$display("%s: no matrix transaction arrived within %0d cycles", name, tx_timeout);
		test_errs++;
	end else begin
		data = q_data.pop_front();
		bits = q_bits.pop_front();
		frame = q_frame.pop_front();
	end
endtask

// Chip 3 sits in the top word since it is shifted first
function automatic logic [63:0] chain_word(input logic [3:0] addr, input logic [31:0] bytes);
	logic [63:0] w;
	for (int c = 0; c < 4; c++)
		w[c*16 +: 16] = {4'h0, addr, bytes[c*8 +: 8]};
	return w;
endfunction

// **************************************************
// Tests
// **************************************************
task automatic reset_state;
	for (int i = 0; i < 8; i++) begin
		@(negedge clk);
		check_value("reset_state time_now", 64'd0, time_now);
		check_value("reset_state led", 64'd1, 64'(led));
		check_value("reset_state leds_cs", 64'd1, 64'(leds_cs));
		check_value("reset_state leds_clk", 64'd0, 64'(leds_clk));
		check_value("reset_state leds_out", 64'd0, 64'(leds_out));
		check_value("reset_state drclk", 64'd0, 64'(drclk));
	end
	@(posedge clk);
	arst_n <= 1'b1;
	for (int i = 0; i < 100; i++)
		compare_outputs("reset_state");
	finish_test("reset_state");
endtask

task automatic time_load;
	loads_on = 1'b1;
	for (int i = 0; i < 2000; i++)
		compare_outputs("time_load");
	if (loads == 0) begin
		$display("time_load: no time_set_en strobe was issued");
		test_errs++;
	end
	finish_test("time_load");
endtask

task automatic heartbeat;
	for (int i = 0; i < 2000; i++)
		compare_outputs("heartbeat");
	if (beats == 0 || beats_on_load == 0) begin
		$display("heartbeat: %0d rotations, %0d on a load, both must be nonzero",
			beats, beats_on_load);
		test_errs++;
	end
	finish_test("heartbeat");
endtask

task automatic init_sequence;
	logic [3:0] addrs [5];
	logic [7:0] datas [5];
	logic ok;
	logic [63:0] data;
	int bits;
	logic [255:0] frame;
	addrs = '{4'd9, 4'd10, 4'd11, 4'd12, 4'd15};
	datas = '{8'd0, 8'd8, 8'd7, 8'd1, 8'd0};
	for (int i = 0; i < 5; i++) begin
		next_tx("init_sequence", ok, data, bits, frame);
		if (!ok)
			break;
		check_value("init_sequence bits", 64'd64, 64'(bits));
		check_value($sformatf("init_sequence word %0d", i),
			chain_word(addrs[i], {4{datas[i]}}), data);
	end
	finish_test("init_sequence");
endtask

task automatic row_refresh;
	logic ok;
	logic [63:0] data;
	int bits;
	logic [255:0] frame;
	logic [255:0] snap;
	logic [31:0] bytes;
	ok = 1'b1;
	snap = '0;
	for (int s = 0; s < 4 && ok; s++) begin
		for (int r = 1; r <= 8 && ok; r++) begin
			next_tx("row_refresh", ok, data, bits, frame);
			if (ok) begin
				if (r == 1) begin
					if (s > 0 && frame == snap) begin
						$display("row_refresh: frame did not change before sweep %0d", s);
						test_errs++;
					end
					snap = frame;
				end
				for (int c = 0; c < 4; c++)
					bytes[c*8 +: 8] = snap[c*64 + (r-1)*8 +: 8];
				check_value("row_refresh bits", 64'd64, 64'(bits));
				check_value($sformatf("row_refresh sweep %0d row %0d", s, r),
					chain_word(4'(r), bytes), data);
			end
		end
	end
	finish_test("row_refresh");
endtask

initial begin
	void'($urandom(32'h7f1e));
	arst_n = 1'b0;
	time_set = '0;
	time_set_en = 1'b0;
	pin_state = {$urandom, $urandom, $urandom, $urandom};
	core_debug = {$urandom, $urandom, $urandom};
	reset_state();
	time_load();
	heartbeat();
	init_sequence();
	row_refresh();
	$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
	if (total_errs == 0)
		$display("No errors");
	else
		$display("Errors found");
	$finish;
end

endmodule

`default_nettype wire

// File: vlog.f
hw/board_pkg.sv
hw/time_base.sv
hw/matrix_display.sv
hw/board_top.sv
sim/board_tb.sv
